//--- design/rv32i_isa_pkg.sv
package rv32i_isa_pkg;

    // ************************************************************
    // field widths fixed by the base ISA
    // ************************************************************
    localparam int INSTR_W    = 32;                     // one instruction word
    localparam int OPCODE_W   = 7;                      // major opcode field
    localparam int REG_ADDR_W = 5;                      // x0..x31

    typedef logic [INSTR_W-1:0]    instr_t;             // raw instruction word
    typedef logic [OPCODE_W-1:0]   opcode_t;            // bits 6:0 of the word
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;          // register file address

    // ************************************************************
    // major opcodes seen by the hazard logic
    // ************************************************************
    localparam opcode_t OPCODE_OP     = 7'b0110011;     // reg-reg alu
    localparam opcode_t OPCODE_OP_IMM = 7'b0010011;     // reg-imm alu
    localparam opcode_t OPCODE_LOAD   = 7'b0000011;     // lb/lh/lw/lbu/lhu
    localparam opcode_t OPCODE_STORE  = 7'b0100011;     // sb/sh/sw
    localparam opcode_t OPCODE_BRANCH = 7'b1100011;     // beq..bgeu
    localparam opcode_t OPCODE_JAL    = 7'b1101111;     // no source regs
    localparam opcode_t OPCODE_LUI    = 7'b0110111;     // no source regs

    // source register field positions, same in every format that has them
    localparam int RS1_LSB = 15;                        // rs1 = [19:15]
    localparam int RS2_LSB = 20;                        // rs2 = [24:20]

endpackage

//--- design/hazard_ctrl_pkg.sv
package hazard_ctrl_pkg;

    // ************************************************************
    // control hazard timing
    // ************************************************************

    // IF/ID is flushed in the trigger cycle and the one after it,
    // the second cycle covers the instruction fetched behind the
    // branch or jump before the new pc takes effect
    localparam int FLUSH_CYCLES = 2;                    // if/id flush length

    // sequencer states
    typedef enum logic [0:0] {
        FLUSH_IDLE   = 1'b0,                            // no flush pending
        FLUSH_SECOND = 1'b1                             // trailing flush cycle
    } flush_state_t;

endpackage

//--- design/load_use_detector.sv
module load_use_detector import rv32i_isa_pkg::*; (
    input  instr_t    if_instr_i,                       // word in IF pipeline reg
    input  logic      id_mem_rd_en_i,                   // load sitting in ID
    input  reg_addr_t id_rd_addr_i,                     // its destination
    output logic      load_use_o                        // dependent read in IF
);

    // ************************************************************
    // field extraction
    // ************************************************************
    opcode_t   opcode;                                  // major opcode
    reg_addr_t rs1_addr;                                // source 1 field
    reg_addr_t rs2_addr;                                // source 2 field

    assign opcode   = if_instr_i[$bits(opcode_t)-1:0];
    assign rs1_addr = if_instr_i[RS1_LSB +: $bits(reg_addr_t)];
    assign rs2_addr = if_instr_i[RS2_LSB +: $bits(reg_addr_t)];

    // ************************************************************
    // which sources the opcode really reads
    // ************************************************************
    logic uses_rs1;                                     // rs1 field is live
    logic uses_rs2;                                     // rs2 field is live

    always_comb begin
        uses_rs1 = 1'b0;                                // jal, lui, others
        uses_rs2 = 1'b0;
        case (opcode)
            OPCODE_OP,
            OPCODE_BRANCH,
            OPCODE_STORE: begin                         // two register operands
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            OPCODE_OP_IMM,
            OPCODE_LOAD: begin                          // base/operand in rs1 only
                uses_rs1 = 1'b1;
            end
            default: begin
                uses_rs1 = 1'b0;                        // nothing read
                uses_rs2 = 1'b0;
            end
        endcase
    end

    // ************************************************************
    // compare against the load destination
    // ************************************************************
    logic rs1_hit;                                      // rs1 == load rd
    logic rs2_hit;                                      // rs2 == load rd

    // x0 is not filtered out, a load to x0 still stalls one cycle
    assign rs1_hit = uses_rs1 && (rs1_addr == id_rd_addr_i);
    assign rs2_hit = uses_rs2 && (rs2_addr == id_rd_addr_i);

    assign load_use_o = id_mem_rd_en_i && (rs1_hit || rs2_hit); // data not ready yet

endmodule

//--- design/flush_sequencer.sv
module flush_sequencer import hazard_ctrl_pkg::*; (
    input  logic Clk,
    input  logic reset_i,
    input  logic branch_taken_i,                        // strobe from EX
    input  logic jump_i,                                // strobe from ID
    output logic if_id_flush_o,                         // trigger cycle + one
    output logic ex_flush_o                             // trigger cycle only
);

    // two states cover exactly one trailing cycle
    if (FLUSH_CYCLES != 2) begin : g_len_check
        $error("flush_sequencer only implements a two-cycle flush");
    end

    flush_state_t state;                                // current state
    flush_state_t state_nxt;                            // next state
    logic         trigger;                              // any redirect

    assign trigger = branch_taken_i || jump_i;

    // ************************************************************
    // state machine
    // ************************************************************
    assign state_nxt = trigger ? FLUSH_SECOND : FLUSH_IDLE; // a trigger opens or restarts the window

    always_ff @(posedge Clk) begin
        if (reset_i) begin
            state <= FLUSH_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ************************************************************
    // outputs
    // ************************************************************
    assign if_id_flush_o = trigger || (state == FLUSH_SECOND); // first or second cycle

    // jumps resolve in ID so the EX instruction is still good
    assign ex_flush_o = branch_taken_i;                 // branch only

endmodule

//--- design/pipeline_control.sv
module pipeline_control (
    input  logic load_use_i,                            // dependent read on a load
    input  logic dmem_wr_busy_i,                        // data memory still writing
    input  logic if_id_flush_i,                         // from flush sequencer
    input  logic ex_flush_i,                            // from flush sequencer
    output logic stall_o,                               // freeze pc and IF/ID
    output logic if_id_flush_o,                         // bubble IF and ID
    output logic ex_flush_o                             // bubble EX
);

    // ************************************************************
    // stall priority
    // ************************************************************
    logic load_use_stall;                               // load-use after priority
    logic mem_stall;                                    // memory write in progress

    // the dependent instruction is thrown away by the flush, so
    // holding it back for the load would only cost a cycle
    assign load_use_stall = load_use_i && !if_id_flush_i;

    // a pending store must finish whatever the control flow does
    assign mem_stall = dmem_wr_busy_i;

    assign stall_o = mem_stall || load_use_stall;       // either cause

    // ************************************************************
    // flushes
    // ************************************************************

    // no stall condition masks a flush, the redirect always wins
    assign if_id_flush_o = if_id_flush_i;               // two-cycle window
    assign ex_flush_o    = ex_flush_i;                  // taken branch only

endmodule

//--- design/hazard_unit.sv
module hazard_unit import rv32i_isa_pkg::*; (
    input  logic      Clk,
    input  logic      reset_i,
    input  instr_t    if_instr_i,                       // IF pipeline reg word
    input  logic      id_mem_rd_en_i,                   // ID holds a load
    input  reg_addr_t id_rd_addr_i,                     // ID destination
    input  logic      ex_branch_taken_i,                // one-cycle strobe
    input  logic      id_jump_i,                        // one-cycle strobe
    input  logic      dmem_wr_busy_i,                   // level
    output logic      stall_o,
    output logic      if_id_flush_o,
    output logic      ex_flush_o
);

    logic load_use;                                     // data hazard flag
    logic if_id_flush;                                  // sequencer if/id flush
    logic ex_flush;                                     // sequencer ex flush

    // ************************************************************
    // data hazard path
    // ************************************************************
    load_use_detector u_load_use (
        .if_instr_i     (if_instr_i),
        .id_mem_rd_en_i (id_mem_rd_en_i),
        .id_rd_addr_i   (id_rd_addr_i),
        .load_use_o     (load_use)
    );

    // ************************************************************
    // control hazard path
    // ************************************************************
    flush_sequencer u_flush_seq (
        .Clk            (Clk),
        .reset_i        (reset_i),
        .branch_taken_i (ex_branch_taken_i),
        .jump_i         (id_jump_i),
        .if_id_flush_o  (if_id_flush),
        .ex_flush_o     (ex_flush)
    );

    // ************************************************************
    // merge both paths
    // ************************************************************
    pipeline_control u_pipe_ctrl (
        .load_use_i     (load_use),
        .dmem_wr_busy_i (dmem_wr_busy_i),
        .if_id_flush_i  (if_id_flush),
        .ex_flush_i     (ex_flush),
        .stall_o        (stall_o),
        .if_id_flush_o  (if_id_flush_o),
        .ex_flush_o     (ex_flush_o)
    );

endmodule

//--- tb/hazard_unit_asserts.sv
module hazard_unit_asserts (
    input logic Clk,
    input logic reset_i,
    input logic ex_branch_taken_i,                      // branch strobe
    input logic id_jump_i,                              // jump strobe
    input logic dmem_wr_busy_i,                         // memory write level
    input logic stall_o,
    input logic if_id_flush_o,
    input logic ex_flush_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // ************************************************************
    // flush and stall relations at the top level
    // ************************************************************
    a_ex_within_if_id : assert property (@(posedge Clk) disable iff (reset_i)
        ex_flush_o |-> if_id_flush_o)                   // ex flush only with if/id flush
        else $error("ex_flush_o high while if_id_flush_o is low");

    a_trigger_trailing : assert property (@(posedge Clk) disable iff (reset_i)
        (ex_branch_taken_i || id_jump_i) |=> if_id_flush_o) // second flush cycle
        else $error("if_id_flush_o not held in the cycle after a trigger");

    a_mem_stall : assert property (@(posedge Clk) disable iff (reset_i)
        dmem_wr_busy_i |-> stall_o)                     // no flush masks it
        else $error("dmem_wr_busy_i high without stall_o");

endmodule

bind hazard_unit hazard_unit_asserts u_asserts (
    .Clk               (Clk),
    .reset_i           (reset_i),
    .ex_branch_taken_i (ex_branch_taken_i),
    .id_jump_i         (id_jump_i),
    .dmem_wr_busy_i    (dmem_wr_busy_i),
    .stall_o           (stall_o),
    .if_id_flush_o     (if_id_flush_o),
    .ex_flush_o        (ex_flush_o)
);

//--- tb/hazard_unit_tb.sv
module hazard_unit_tb
    import rv32i_isa_pkg::*,
           hazard_ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // ************************************************************
    // run length
    // ************************************************************
    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 8;
    localparam int DIRECTED_CYCLES = 64;                // upper bound, directed part
    localparam int RANDOM_CYCLES   = 2000;
    localparam int TEST_CYCLES     = DIRECTED_CYCLES + RANDOM_CYCLES;
    localparam int WATCHDOG_NS     = (TEST_CYCLES + RESET_CYCLES + 20) * CLK_PERIOD;

    logic      Clk;
    logic      reset_i;
    instr_t    if_instr_i;
    logic      id_mem_rd_en_i;
    reg_addr_t id_rd_addr_i;
    logic      ex_branch_taken_i;
    logic      id_jump_i;
    logic      dmem_wr_busy_i;
    logic      stall_o;
    logic      if_id_flush_o;
    logic      ex_flush_o;

    logic [15:0] lfsr_state = 16'd29543;                // stimulus generator
    int          flush_left = 0;                        // reference trailing flush count
    opcode_t     opcode_list [7] = '{OPCODE_OP, OPCODE_OP_IMM, OPCODE_LOAD, OPCODE_STORE,
                                     OPCODE_BRANCH, OPCODE_JAL, OPCODE_LUI};

    hazard_unit dut_i (
        .Clk               (Clk),
        .reset_i           (reset_i),
        .if_instr_i        (if_instr_i),
        .id_mem_rd_en_i    (id_mem_rd_en_i),
        .id_rd_addr_i      (id_rd_addr_i),
        .ex_branch_taken_i (ex_branch_taken_i),
        .id_jump_i         (id_jump_i),
        .dmem_wr_busy_i    (dmem_wr_busy_i),
        .stall_o           (stall_o),
        .if_id_flush_o     (if_id_flush_o),
        .ex_flush_o        (ex_flush_o)
    );

    initial begin : clock_gen
        Clk = 1'b0;
        forever #(CLK_PERIOD / 2) Clk = ~Clk;
    end

    // ************************************************************
    // random bits, x^16 + x^14 + x^13 + x^11 + 1
    // ************************************************************
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);         // one step per bit
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic instr_t make_instr(input opcode_t op, input reg_addr_t rd,
                                          input reg_addr_t rs1, input reg_addr_t rs2,
                                          input instr_t filler);
        instr_t w;
        w = filler;                                     // funct bits don't matter
        w[6:0] = op;
        w[11:7] = rd;
        w[RS1_LSB +: 5] = rs1;
        w[RS2_LSB +: 5] = rs2;
        return w;
    endfunction

    // ************************************************************
    // reference model, returns {stall, if_id_flush, ex_flush}
    // ************************************************************
    function automatic logic [2:0] expected_controls(input instr_t instr, input logic rd_en,
                                                     input reg_addr_t rd_addr,
                                                     input logic branch, input logic jump,
                                                     input logic busy, input logic pending);
        opcode_t   op;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      reads_rs1;
        logic      reads_rs2;
        logic      hit;
        logic      if_id;
        op  = instr[6:0];
        rs1 = instr[RS1_LSB +: 5];
        rs2 = instr[RS2_LSB +: 5];
        reads_rs2 = (op == OPCODE_OP) || (op == OPCODE_BRANCH) || (op == OPCODE_STORE);
        reads_rs1 = reads_rs2 || (op == OPCODE_OP_IMM) || (op == OPCODE_LOAD);
        hit   = rd_en && ((reads_rs1 && rs1 == rd_addr) || (reads_rs2 && rs2 == rd_addr));
        if_id = branch || jump || pending;              // trigger or trailing cycle
        return {busy || (hit && !if_id), if_id, branch};
    endfunction

    // ************************************************************
    // checking
    // ************************************************************
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_stall(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at %0t: %s is %b, expected %b",
                                $time, what, actual, expected));
        end
    endtask

    task automatic check_flush(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at %0t: %s is %b, expected %b",
                                $time, what, actual, expected));
        end
    endtask

    initial begin : compare_outputs
        logic [2:0] exp_ctrl;
        forever begin
            @(posedge Clk);
            #(CLK_PERIOD - 1);                          // just before next edge
            if (reset_i) begin
                flush_left = 0;
            end else begin
                exp_ctrl = expected_controls(if_instr_i, id_mem_rd_en_i, id_rd_addr_i,
                                             ex_branch_taken_i, id_jump_i, dmem_wr_busy_i,
                                             flush_left > 0);
                check_stall(stall_o, exp_ctrl[2], "stall_o");
                check_flush(if_id_flush_o, exp_ctrl[1], "if_id_flush_o");
                check_flush(ex_flush_o, exp_ctrl[0], "ex_flush_o");
                if (ex_branch_taken_i || id_jump_i) begin
                    flush_left = FLUSH_CYCLES - 1;      // window restarts
                end else if (flush_left > 0) begin
                    flush_left = flush_left - 1;
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        abort_run("timeout, the test did not finish in the expected number of cycles");
    end

    // ************************************************************
    // stimulus
    // ************************************************************
    task automatic drive(input instr_t instr, input logic rd_en, input reg_addr_t rd_addr,
                         input logic branch, input logic jump, input logic busy);
        @(posedge Clk);
        #1;                                             // clear of the edge
        if_instr_i        = instr;
        id_mem_rd_en_i    = rd_en;
        id_rd_addr_i      = rd_addr;
        ex_branch_taken_i = branch;
        id_jump_i         = jump;
        dmem_wr_busy_i    = busy;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) drive('0, 1'b0, '0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic random_run(input int cycles);
        instr_t    instr;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        int        idx;
        for (int n = 0; n < cycles; n++) begin
            idx   = int'(take_bits(3) % $size(opcode_list));
            rd    = reg_addr_t'(take_bits(5));
            rs1   = reg_addr_t'(take_bits(3));          // x0..x7, frequent matches
            rs2   = reg_addr_t'(take_bits(3));
            instr = make_instr(opcode_list[idx], rd, rs1, rs2, take_bits(32));
            drive(instr, take_bits(1) != 0, reg_addr_t'(take_bits(3)),
                  take_bits(3) == 0, take_bits(3) == 0, take_bits(3) == 0);
        end
    endtask

    initial begin : main
        instr_t match_op;
        reset_i           = 1'b1;
        if_instr_i        = '0;
        id_mem_rd_en_i    = 1'b0;
        id_rd_addr_i      = '0;
        ex_branch_taken_i = 1'b0;
        id_jump_i         = 1'b0;
        dmem_wr_busy_i    = 1'b0;
        repeat (RESET_CYCLES) @(posedge Clk);
        #1 reset_i = 1'b0;
        idle(3);                                        // all outputs low

        // load-use per opcode class, rs1 = x5 and rs2 = x6
        foreach (opcode_list[i]) begin
            drive(make_instr(opcode_list[i], 5'd1, 5'd5, 5'd6, '0), 1'b1, 5'd5, 1'b0, 1'b0, 1'b0);
            drive(make_instr(opcode_list[i], 5'd1, 5'd5, 5'd6, '0), 1'b1, 5'd6, 1'b0, 1'b0, 1'b0);
            drive(make_instr(opcode_list[i], 5'd1, 5'd5, 5'd6, '0), 1'b1, 5'd7, 1'b0, 1'b0, 1'b0);
            drive(make_instr(opcode_list[i], 5'd1, 5'd5, 5'd6, '0), 1'b0, 5'd5, 1'b0, 1'b0, 1'b0);
        end

        drive('0, 1'b0, '0, 1'b1, 1'b0, 1'b0);          // single branch
        idle(FLUSH_CYCLES);
        drive('0, 1'b0, '0, 1'b0, 1'b1, 1'b0);          // single jump
        idle(FLUSH_CYCLES);
        drive('0, 1'b0, '0, 1'b1, 1'b0, 1'b0);          // back to back
        drive('0, 1'b0, '0, 1'b0, 1'b1, 1'b0);
        drive('0, 1'b0, '0, 1'b1, 1'b0, 1'b0);
        idle(FLUSH_CYCLES);

        // load-use masked in both flush cycles, then it stalls
        match_op = make_instr(OPCODE_OP, 5'd2, 5'd9, 5'd3, '0);
        drive(match_op, 1'b1, 5'd9, 1'b0, 1'b1, 1'b0);
        drive(match_op, 1'b1, 5'd9, 1'b0, 1'b0, 1'b0);
        drive(match_op, 1'b1, 5'd9, 1'b0, 1'b0, 1'b0);
        drive(match_op, 1'b1, 5'd9, 1'b1, 1'b0, 1'b1);  // busy wins over flush
        drive('0, 1'b0, '0, 1'b0, 1'b0, 1'b1);
        idle(FLUSH_CYCLES);

        random_run(RANDOM_CYCLES);
        idle(1);
        repeat (2) @(posedge Clk);                      // let the last compare run
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- src.f
design/rv32i_isa_pkg.sv
design/hazard_ctrl_pkg.sv
design/load_use_detector.sv
design/flush_sequencer.sv
design/pipeline_control.sv
design/hazard_unit.sv
tb/hazard_unit_asserts.sv
tb/hazard_unit_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = hazard_unit_tb
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Finished with no errors" $(LOG); then \
		echo "TEST PASSED"; \
	else \
		echo "TEST FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
